// ==== source/rtcMenuPkg.sv ====
`default_nettype none

package rtcMenuPkg;

	//////////////////////////////////////////////////////////////////////
	// State and opcode types
	//////////////////////////////////////////////////////////////////////

	// Main menu sequencing
	typedef enum logic [1:0]
	{
		IDLE,
		SCAN,
		PAUSE,
		CHECK
	} menuStateT;

	// Register walk, one access per register
	typedef enum logic [1:0]
	{
		SIDLE,
		REQ,
		WAITDONE,
		STEP
	} scanStateT;

	//////////////////////////////////////////////////////////////////////
	// Register map
	//////////////////////////////////////////////////////////////////////

	localparam int NUM_REGS = 11;
	// Time registers only, indexes 0 to 6
	localparam int NUM_EDIT = 7;

	typedef logic [3:0] regIdxT;

	// Time block then timer block, scan order is index order
	localparam logic [6:0] addrTable [NUM_REGS] = '{
		7'h21, 7'h22, 7'h23, 7'h24, 7'h25, 7'h26, 7'h27,
		7'h41, 7'h42, 7'h43, 7'h44
	};

	// Wrap point per register
	// sec, min, hour, weekday, day, month, year, then timers
	localparam logic [7:0] limitTable [NUM_REGS] = '{
		8'd59, 8'd59, 8'd23, 8'd7, 8'd31, 8'd12, 8'd99,
		8'd255, 8'd255, 8'd255, 8'd255
	};

	// Idle cycles between scans
	localparam int PAUSE_CYCLES = 5;
	localparam regIdxT EDIT_RESET_IDX = 4'd0;

	//////////////////////////////////////////////////////////////////////
	// Bundles
	//////////////////////////////////////////////////////////////////////

	// Panel button levels
	typedef struct packed
	{
		logic up;
		logic down;
		logic left;
		logic right;
		logic centre;
	} buttonsT;

	// One access toward the RTC interface
	typedef struct packed
	{
		logic       valid;
		logic       write;
		logic [6:0] addr;
		logic [7:0] wrData;
	} rtcReqT;

	// Completion from the RTC interface
	typedef struct packed
	{
		logic       done;
		logic [7:0] rdData;
	} rtcRspT;

endpackage

`default_nettype wire

// ==== source/waitTimer.sv ====
`timescale 1ns/1ns
`default_nettype none

module waitTimer
	import rtcMenuPkg::*;
(
	input  wire  CLK,
	input  wire  RST,
	input  wire  pauseStart,
	output logic pauseDone
);

	// Zero means idle
	logic [7:0] waitCount;

	//////////////////////////////////////////////////////////////////////
	// Down-counter
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			waitCount <= '0;
		end
		else if (pauseStart)
		begin
			waitCount <= 8'(PAUSE_CYCLES);
		end
		else if (waitCount != 8'd0)
		begin
			waitCount <= waitCount - 8'd1;
		end
	end

	// Last count, expires PAUSE_CYCLES after the start
	assign pauseDone = (waitCount == 8'd1);

endmodule

`default_nettype wire

// ==== source/timeShadow.sv ====
`timescale 1ns/1ns
`default_nettype none

module timeShadow
	import rtcMenuPkg::*;
(
	input  wire        CLK,
	input  wire        RST,
	input  wire  [3:0] scanIdx,
	input  wire        rdCapture,
	input  wire  [7:0] rdData,
	input  wire        buttonsT editCmd,
	input  wire        clearPtr,
	output logic [7:0] shadowData,
	output regIdxT     editIdx,
	output logic [7:0] editValue
);

	localparam regIdxT LAST_EDIT = regIdxT'(NUM_EDIT - 1);

	logic [7:0] shadow [NUM_REGS];
	logic [7:0] editLimit;
	logic [7:0] editValueNext;
	regIdxT     editIdxNext;

	//////////////////////////////////////////////////////////////////////
	// Value edit
	//////////////////////////////////////////////////////////////////////

	assign editLimit = limitTable[editIdx];

	always_comb
	begin
		editValueNext = editValue;
		// Up wins over down
		if (editCmd.up)
			editValueNext = (editValue == editLimit) ? 8'd0 : editValue + 8'd1;
		else if (editCmd.down)
			editValueNext = (editValue == 8'd0) ? editLimit : editValue - 8'd1;
	end

	//////////////////////////////////////////////////////////////////////
	// Pointer move
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		editIdxNext = editIdx;
		if (clearPtr)
			editIdxNext = EDIT_RESET_IDX;
		// Left wins over right, wrap over the time registers
		else if (editCmd.left)
			editIdxNext = (editIdx == 4'd0) ? LAST_EDIT : editIdx - 4'd1;
		else if (editCmd.right)
			editIdxNext = (editIdx == LAST_EDIT) ? 4'd0 : editIdx + 4'd1;
	end

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			editIdx <= EDIT_RESET_IDX;
			for (int i = 0; i < NUM_REGS; i++)
				shadow[i] <= '0;
		end
		else
		begin
			editIdx <= editIdxNext;
			// Captures only in a read scan, edits only in CHECK
			if (rdCapture)
				shadow[scanIdx] <= rdData;
			else if (editCmd.up || editCmd.down)
				shadow[editIdx] <= editValueNext;
		end
	end

	// Write-back source during a scan
	assign shadowData = shadow[scanIdx];
	// Value under the pointer, for the panel
	assign editValue  = shadow[editIdx];

endmodule

`default_nettype wire

// ==== source/addrScanner.sv ====
`timescale 1ns/1ns
`default_nettype none

module addrScanner
	import rtcMenuPkg::*;
(
	input  wire        CLK,
	input  wire        RST,
	input  wire        scanStart,
	input  wire        modify,
	input  wire  [7:0] shadowData,
	input  wire        rtcRspT rtcRsp,
	output rtcReqT     rtcReq,
	output regIdxT     scanIdx,
	output logic       rdCapture,
	output logic       scanDone
);

	localparam regIdxT LAST_IDX = regIdxT'(NUM_REGS - 1);

	scanStateT scanState;
	scanStateT scanStateNext;
	regIdxT    scanIdxNext;

	//////////////////////////////////////////////////////////////////////
	// Walk registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			scanState <= SIDLE;
			scanIdx   <= '0;
		end
		else
		begin
			scanState <= scanStateNext;
			scanIdx   <= scanIdxNext;
		end
	end

	always_comb
	begin
		scanStateNext = scanState;
		scanIdxNext   = scanIdx;
		rdCapture     = 1'b0;
		scanDone      = 1'b0;
		case (scanState)
			SIDLE:
			begin
				if (scanStart)
					scanStateNext = REQ;
			end
			// Request goes out for one cycle
			REQ:
			begin
				scanStateNext = WAITDONE;
			end
			WAITDONE:
			begin
				if (rtcRsp.done)
				begin
					// Read data only valid with done
					rdCapture     = ~modify;
					scanStateNext = STEP;
				end
			end
			STEP:
			begin
				if (scanIdx == LAST_IDX)
				begin
					scanDone      = 1'b1;
					scanIdxNext   = '0;
					scanStateNext = SIDLE;
				end
				else
				begin
					// Table lookup covers the 0x27 to 0x41 gap
					scanIdxNext   = scanIdx + 4'd1;
					scanStateNext = REQ;
				end
			end
			default:
			begin
				scanStateNext = SIDLE;
			end
		endcase
	end

	// Access port, write direction fixed for the whole scan
	always_comb
	begin
		rtcReq.valid  = (scanState == REQ);
		rtcReq.write  = modify;
		rtcReq.addr   = addrTable[scanIdx];
		rtcReq.wrData = shadowData;
	end

endmodule

`default_nettype wire

// ==== source/menuFsm.sv ====
`timescale 1ns/1ns
`default_nettype none

module menuFsm
	import rtcMenuPkg::*;
(
	input  wire     CLK,
	input  wire     RST,
	input  wire     rtcReady,
	input  wire     buttonsT buttons,
	input  wire     scanDone,
	input  wire     pauseDone,
	output logic    scanStart,
	output logic    pauseStart,
	output logic    clearPtr,
	output logic    modify,
	output buttonsT editCmd
);

	//////////////////////////////////////////////////////////////////////
	// State and modify flag
	//////////////////////////////////////////////////////////////////////

	menuStateT menuState;
	menuStateT menuStateNext;
	logic      modifyNext;

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			menuState <= IDLE;
			modify    <= 1'b0;
		end
		else
		begin
			menuState <= menuStateNext;
			modify    <= modifyNext;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Next state and pulses
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		menuStateNext = menuState;
		modifyNext    = modify;
		scanStart     = 1'b0;
		pauseStart    = 1'b0;
		clearPtr      = 1'b0;
		// Buttons reach the shadow only in CHECK
		editCmd       = '0;
		case (menuState)
			IDLE:
			begin
				// Wait for the RTC side to come up
				if (rtcReady)
				begin
					scanStart     = 1'b1;
					menuStateNext = SCAN;
				end
			end
			SCAN:
			begin
				if (scanDone)
				begin
					pauseStart    = 1'b1;
					menuStateNext = PAUSE;
					// Write-back finished, back to reading
					if (modify)
					begin
						modifyNext = 1'b0;
						clearPtr   = 1'b1;
					end
				end
			end
			PAUSE:
			begin
				if (pauseDone)
					menuStateNext = CHECK;
			end
			CHECK:
			begin
				// Single cycle, buttons sampled once
				editCmd = buttons;
				if (buttons.centre)
					modifyNext = 1'b1;
				scanStart     = 1'b1;
				menuStateNext = SCAN;
			end
			default:
			begin
				menuStateNext = IDLE;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== source/rtcMenuTop.sv ====
`timescale 1ns/1ns
`default_nettype none

module rtcMenuTop
	import rtcMenuPkg::*;
(
	input  wire        CLK,
	input  wire        RST,
	input  wire        rtcReady,
	input  wire        buttonsT buttons,
	output rtcReqT     rtcReq,
	input  wire        rtcRspT rtcRsp,
	output regIdxT     editIdx,
	output logic [7:0] editValue,
	output logic       modify
);

	// Sequencing handshakes
	logic       scanStart;
	logic       scanDone;
	logic       pauseStart;
	logic       pauseDone;
	logic       clearPtr;
	buttonsT    editCmd;
	// Scan datapath
	regIdxT     scanIdx;
	logic       rdCapture;
	logic [7:0] shadowData;

	//////////////////////////////////////////////////////////////////////
	// Control
	//////////////////////////////////////////////////////////////////////

	menuFsm uMenuFsm
	(
		.CLK        (CLK),
		.RST        (RST),
		.rtcReady   (rtcReady),
		.buttons    (buttons),
		.scanDone   (scanDone),
		.pauseDone  (pauseDone),
		.scanStart  (scanStart),
		.pauseStart (pauseStart),
		.clearPtr   (clearPtr),
		.modify     (modify),
		.editCmd    (editCmd)
	);

	waitTimer uWaitTimer
	(
		.CLK        (CLK),
		.RST        (RST),
		.pauseStart (pauseStart),
		.pauseDone  (pauseDone)
	);

	//////////////////////////////////////////////////////////////////////
	// RTC access and shadow
	//////////////////////////////////////////////////////////////////////

	addrScanner uAddrScanner
	(
		.CLK        (CLK),
		.RST        (RST),
		.scanStart  (scanStart),
		.modify     (modify),
		.shadowData (shadowData),
		.rtcRsp     (rtcRsp),
		.rtcReq     (rtcReq),
		.scanIdx    (scanIdx),
		.rdCapture  (rdCapture),
		.scanDone   (scanDone)
	);

	timeShadow uTimeShadow
	(
		.CLK        (CLK),
		.RST        (RST),
		.scanIdx    (scanIdx),
		.rdCapture  (rdCapture),
		.rdData     (rtcRsp.rdData),
		.editCmd    (editCmd),
		.clearPtr   (clearPtr),
		.shadowData (shadowData),
		.editIdx    (editIdx),
		.editValue  (editValue)
	);

endmodule

`default_nettype wire

// ==== testbench/rtcMenu_props.sv ====
`timescale 1ns/1ns
`default_nettype none

module rtcMenuProps
	import rtcMenuPkg::*;
(
	input wire            CLK,
	input wire            RST,
	input wire            reqValid,
	input wire            rspDone,
	input wire            modify,
	input wire            scanDone,
	input wire menuStateT menuState
);

	// Set by valid, cleared by done
	logic outstanding;

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
			outstanding <= 1'b0;
		else if (reqValid)
			outstanding <= 1'b1;
		else if (rspDone)
			outstanding <= 1'b0;
	end

	//////////////////////////////////////////////////////////////////////
	// Access port
	//////////////////////////////////////////////////////////////////////

	noReqWhileBusy: assert property (@(posedge CLK) disable iff (RST)
		outstanding |-> !reqValid)
		else $error("request issued while an access is outstanding");

	// Responder latency is at most four cycles
	reqGetsDone: assert property (@(posedge CLK) disable iff (RST)
		reqValid |-> ##[1:8] rspDone)
		else $error("request never answered by done");

	doneHasReq: assert property (@(posedge CLK) disable iff (RST)
		rspDone |-> outstanding)
		else $error("done without an outstanding request");

	//////////////////////////////////////////////////////////////////////
	// Menu sequencing
	//////////////////////////////////////////////////////////////////////

	modifyHeldInScan: assert property (@(posedge CLK) disable iff (RST)
		(menuState == SCAN && !scanDone) |=> $stable(modify))
		else $error("modify changed in the middle of a scan");

	checkOneCycle: assert property (@(posedge CLK) disable iff (RST)
		(menuState == CHECK) |=> (menuState == SCAN))
		else $error("CHECK did not return to SCAN after one cycle");

endmodule

// Port checks on the scanner, menu side tied off
bind addrScanner rtcMenuProps scanProps
(
	.CLK       (CLK),
	.RST       (RST),
	.reqValid  (rtcReq.valid),
	.rspDone   (rtcRsp.done),
	.modify    (modify),
	.scanDone  (scanDone),
	.menuState (rtcMenuPkg::IDLE)
);

// FSM checks, access port tied off
bind menuFsm rtcMenuProps menuProps
(
	.CLK       (CLK),
	.RST       (RST),
	.reqValid  (1'b0),
	.rspDone   (1'b0),
	.modify    (modify),
	.scanDone  (scanDone),
	.menuState (menuState)
);

`default_nettype wire

// ==== testbench/rtcMenuTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module rtcMenuTb
	import rtcMenuPkg::*;
();

	localparam int CLK_PERIOD = 10;
	localparam int RAND_SEED  = 45;
	localparam int NUM_ROUNDS = 19;
	// Access takes at most 7 cycles, 8 leaves slack
	localparam int WATCHDOG_NS =
		(NUM_ROUNDS + 2) * (NUM_REGS * 8 + PAUSE_CYCLES + 4) * CLK_PERIOD + 500;
	// Last done to next valid: STEP, pause, CHECK, REQ, then the sampling edge
	localparam longint GAP_NS = (PAUSE_CYCLES + 4) * CLK_PERIOD;

	localparam buttonsT BTN_NONE   = 5'b00000;
	localparam buttonsT BTN_UP     = 5'b10000;
	localparam buttonsT BTN_DOWN   = 5'b01000;
	localparam buttonsT BTN_LEFT   = 5'b00100;
	localparam buttonsT BTN_RIGHT  = 5'b00010;
	localparam buttonsT BTN_CENTRE = 5'b00001;

	typedef struct packed
	{
		buttonsT    btn;
		logic       poke;
		logic [6:0] pokeAddr;
		logic [7:0] pokeData;
		regIdxT     expIdx;
		logic [7:0] expValue;
	} roundT;

	// Buttons, memory poke before CHECK, pointer and value after CHECK
	localparam roundT ROUNDS [NUM_ROUNDS] = '{
		'{BTN_NONE,               1'b0, 7'h00, 8'd0,  4'd0, 8'd59},
		'{BTN_UP,                 1'b0, 7'h00, 8'd0,  4'd0, 8'd0},
		'{BTN_RIGHT,              1'b0, 7'h00, 8'd0,  4'd1, 8'd30},
		'{BTN_LEFT,               1'b0, 7'h00, 8'd0,  4'd0, 8'd59},
		'{BTN_LEFT,               1'b0, 7'h00, 8'd0,  4'd6, 8'd24},
		'{BTN_RIGHT,              1'b0, 7'h00, 8'd0,  4'd0, 8'd59},
		'{BTN_LEFT | BTN_RIGHT,   1'b0, 7'h00, 8'd0,  4'd6, 8'd24},
		'{BTN_LEFT,               1'b0, 7'h00, 8'd0,  4'd5, 8'd0},
		'{BTN_DOWN,               1'b0, 7'h00, 8'd0,  4'd5, 8'd12},
		'{BTN_UP | BTN_DOWN,      1'b0, 7'h00, 8'd0,  4'd5, 8'd1},
		'{BTN_DOWN | BTN_CENTRE,  1'b0, 7'h00, 8'd0,  4'd5, 8'd12},
		'{BTN_NONE,               1'b0, 7'h00, 8'd0,  4'd0, 8'd59},
		'{BTN_LEFT,               1'b0, 7'h00, 8'd0,  4'd6, 8'd24},
		'{BTN_LEFT,               1'b0, 7'h00, 8'd0,  4'd5, 8'd12},
		'{BTN_LEFT,               1'b1, 7'h25, 8'd27, 4'd4, 8'd15},
		'{BTN_NONE,               1'b0, 7'h00, 8'd0,  4'd4, 8'd27},
		'{BTN_LEFT,               1'b0, 7'h00, 8'd0,  4'd3, 8'd3},
		'{BTN_LEFT,               1'b0, 7'h00, 8'd0,  4'd2, 8'd23},
		'{BTN_UP,                 1'b0, 7'h00, 8'd0,  4'd2, 8'd0}
	};

	// Chip contents in scan order, month starts at 0 for the down wrap
	localparam logic [7:0] PRELOAD [NUM_REGS] = '{
		8'd59, 8'd30, 8'd23, 8'd3, 8'd15, 8'd0, 8'd24,
		8'h10, 8'h20, 8'h30, 8'h40
	};

	logic       CLK;
	logic       RST;
	logic       rtcReady;
	buttonsT    buttons;
	rtcReqT     rtcReq;
	rtcRspT     rtcRsp;
	regIdxT     editIdx;
	logic [7:0] editValue;
	logic       modify;

	// Responder memory and reference model
	logic [7:0] mem [128];
	logic [7:0] expShadow [NUM_REGS];
	regIdxT     expPtr;
	logic       expModify;
	// Access in flight
	logic       busy;
	int         latency;
	int         accCount;
	logic [6:0] reqAddr;
	logic       reqWrite;
	logic [7:0] reqData;
	time        firstReqTime;
	time        lastDoneTime;
	event       scanBegin;
	event       scanEnd;

	rtcMenuTop DUT
	(
		.CLK       (CLK),
		.RST       (RST),
		.rtcReady  (rtcReady),
		.buttons   (buttons),
		.rtcReq    (rtcReq),
		.rtcRsp    (rtcRsp),
		.editIdx   (editIdx),
		.editValue (editValue),
		.modify    (modify)
	);

	initial
	begin
		CLK = 1'b0;
		forever
			#(CLK_PERIOD / 2) CLK = ~CLK;
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	task automatic reportMismatch(input string name, input longint got, input longint expected);
		$display("FAIL t=%0t %s got %0d expected %0d", $time, name, got, expected);
		$display(">>> FAIL");
		$fatal(1, "value mismatch");
	endtask

	task automatic abortRun(input string why);
		$display("ERROR t=%0t %s", $time, why);
		$display(">>> FAIL");
		$fatal(1, "run aborted");
	endtask

	// Time block from 0x21, timer block from 0x41
	function automatic logic [6:0] expectedAddr(input int idx);
		if (idx < NUM_EDIT)
			return 7'(8'h21 + idx);
		return 7'(8'h41 + idx - NUM_EDIT);
	endfunction

	// Value edit on the old pointer, then the move
	task automatic applyButtons(input buttonsT btn);
		logic [7:0] limit;
		limit = limitTable[expPtr];
		if (btn.up)
			expShadow[expPtr] = (expShadow[expPtr] == limit) ? 8'd0 : expShadow[expPtr] + 8'd1;
		else if (btn.down)
			expShadow[expPtr] = (expShadow[expPtr] == 8'd0) ? limit : expShadow[expPtr] - 8'd1;
		if (btn.left)
			expPtr = (expPtr == 4'd0) ? regIdxT'(NUM_EDIT - 1) : expPtr - 4'd1;
		else if (btn.right)
			expPtr = (expPtr == regIdxT'(NUM_EDIT - 1)) ? 4'd0 : expPtr + 4'd1;
		if (btn.centre)
			expModify = 1'b1;
	endtask

	task automatic checkWriteBack();
		for (int i = 0; i < NUM_REGS; i++)
		begin
			assert (mem[expectedAddr(i)] == expShadow[i])
				else reportMismatch("rtc memory", mem[expectedAddr(i)], expShadow[i]);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// RTC responder
	//////////////////////////////////////////////////////////////////////

	task acceptRequest();
		assert (!busy)
			else abortRun("new request while an access is still outstanding");
		assert (rtcReq.addr == expectedAddr(accCount))
			else reportMismatch("rtcReq.addr", rtcReq.addr, expectedAddr(accCount));
		assert (rtcReq.write == expModify)
			else reportMismatch("rtcReq.write", rtcReq.write, expModify);
		if (rtcReq.write)
		begin
			assert (rtcReq.wrData == expShadow[accCount])
				else reportMismatch("rtcReq.wrData", rtcReq.wrData, expShadow[accCount]);
		end
		busy     = 1'b1;
		latency  = $urandom_range(4, 1);
		reqAddr  = rtcReq.addr;
		reqWrite = rtcReq.write;
		reqData  = rtcReq.wrData;
		if (accCount == 0)
		begin
			firstReqTime = $time;
			-> scanBegin;
		end
	endtask

	task completeAccess();
		busy = 1'b0;
		if (reqWrite)
			mem[reqAddr] = reqData;
		else
		begin
			rtcRsp.rdData <= mem[reqAddr];
			// Shadow picks up what the chip returns
			expShadow[accCount] = mem[reqAddr];
		end
		rtcRsp.done <= 1'b1;
		accCount = accCount + 1;
		if (accCount == NUM_REGS)
		begin
			accCount     = 0;
			lastDoneTime = $time;
			-> scanEnd;
		end
	endtask

	always @(posedge CLK)
	begin
		rtcRsp.done <= 1'b0;
		if (RST)
		begin
			busy     = 1'b0;
			accCount = 0;
		end
		else
		begin
			if (busy)
			begin
				latency = latency - 1;
				if (latency == 0)
					completeAccess();
			end
			if (rtcReq.valid)
				acceptRequest();
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus and checks
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		void'($urandom(RAND_SEED));
		RST       = 1'b1;
		rtcReady  = 1'b0;
		buttons   = BTN_NONE;
		rtcRsp    = '0;
		expPtr    = EDIT_RESET_IDX;
		expModify = 1'b0;
		busy      = 1'b0;
		accCount  = 0;
		latency   = 0;
		// Fill depends on the whole address
		for (int a = 0; a < 128; a++)
			mem[a] = 8'(a * 37 + 11);
		for (int i = 0; i < NUM_REGS; i++)
		begin
			mem[expectedAddr(i)] = PRELOAD[i];
			expShadow[i]         = 8'd0;
		end
		repeat (3)
			@(posedge CLK);
		RST <= 1'b0;

		// Nothing moves before ready
		repeat (4)
		begin
			@(negedge CLK);
			assert (rtcReq.valid == 1'b0)
				else reportMismatch("rtcReq.valid", rtcReq.valid, 0);
			assert (modify == 1'b0)
				else reportMismatch("modify", modify, 0);
			assert (editIdx == EDIT_RESET_IDX)
				else reportMismatch("editIdx", editIdx, EDIT_RESET_IDX);
			assert (editValue == 8'd0)
				else reportMismatch("editValue", editValue, 0);
		end
		@(posedge CLK);
		rtcReady <= 1'b1;
		@(scanBegin);

		for (int r = 0; r < NUM_ROUNDS; r++)
		begin
			// Held through the pause, sampled in CHECK
			buttons <= ROUNDS[r].btn;
			@(scanEnd);
			if (expModify)
			begin
				checkWriteBack();
				expModify = 1'b0;
				expPtr    = EDIT_RESET_IDX;
			end
			if (ROUNDS[r].poke)
				mem[ROUNDS[r].pokeAddr] = ROUNDS[r].pokeData;
			applyButtons(ROUNDS[r].btn);
			@(scanBegin);
			assert (firstReqTime - lastDoneTime == GAP_NS)
				else reportMismatch("pause gap ns", firstReqTime - lastDoneTime, GAP_NS);
			assert (editIdx == ROUNDS[r].expIdx)
				else reportMismatch("editIdx", editIdx, ROUNDS[r].expIdx);
			assert (editIdx == expPtr)
				else reportMismatch("editIdx", editIdx, expPtr);
			assert (editValue == ROUNDS[r].expValue)
				else reportMismatch("editValue", editValue, ROUNDS[r].expValue);
			assert (editValue == expShadow[expPtr])
				else reportMismatch("editValue", editValue, expShadow[expPtr]);
			assert (modify == expModify)
				else reportMismatch("modify", modify, expModify);
		end
		$display(">>> PASS");
		$finish;
	end

	// Bound from the worst case scan and pause length
	initial
	begin
		#(WATCHDOG_NS);
		abortRun("watchdog expired before all rounds finished");
	end

endmodule

`default_nettype wire

// ==== compile.f ====
source/rtcMenuPkg.sv
source/waitTimer.sv
source/timeShadow.sv
source/addrScanner.sv
source/menuFsm.sv
source/rtcMenuTop.sv
testbench/rtcMenu_props.sv
testbench/rtcMenuTb.sv

// ==== Bender.yml ====
package:
  name: rtc_menu

sources:
  - source/rtcMenuPkg.sv
  - source/waitTimer.sv
  - source/timeShadow.sv
  - source/addrScanner.sv
  - source/menuFsm.sv
  - source/rtcMenuTop.sv
  - target: simulation
    files:
      - testbench/rtcMenu_props.sv
      - testbench/rtcMenuTb.sv
